// File: Bender.yml
package:
  name: ex_stage

sources:
  - hw/ex_op_pkg.sv
  - hw/ex_bus_pkg.sv
  - hw/ex_alu.sv
  - hw/ex_divider.sv
  - hw/ex_ctrl.sv
  - hw/ex_stage.sv
  - hw/stable_counter.sv
  - hw/ex_top.sv
  - target: test
    files:
      - test/ex_tb.sv

// File: hw/ex_alu.sv
module ex_alu (
    input  ex_op_pkg::alu_op_e            op,
    input  logic [ex_op_pkg::DATA_W-1:0]  a,
    input  logic [ex_op_pkg::DATA_W-1:0]  b,
    output logic [ex_op_pkg::DATA_W-1:0]  result
);

    import ex_op_pkg::*;

    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] diff;
    logic              lt_signed;
    logic              lt_unsigned;
    logic [4:0]        shamt;

    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = b[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_SLT: begin
                result = {{(DATA_W-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(DATA_W-1){1'b0}}, lt_unsigned};
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_NOR: begin
                result = ~(a | b);
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            // Decode already placed the shifted immediate in b
            default: begin
                result = b;
            end
        endcase
    end

endmodule

// File: hw/ex_bus_pkg.sv
package ex_bus_pkg;

    import ex_op_pkg::*;

    // Decode to execute
    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] src1;
        logic [DATA_W-1:0] src2;
        alu_op_e           alu_op;
        ex_kind_e          kind;
        div_kind_e         div_kind;
        logic              mem_rd;
        logic              mem_wr;
        mem_size_e         mem_size;
        logic              mem_signed;
        logic              gr_we;
        logic [4:0]        rf_waddr;
        logic [DATA_W-1:0] store_data;
        logic [3:0]        except_in;
    } id_to_ex_t;

    // Execute to memory, ale is the low bit of except_out
    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] result;
        logic              mem_rd;
        logic              mem_wr;
        mem_size_e         mem_size;
        logic              mem_signed;
        logic              gr_we;
        logic [4:0]        rf_waddr;
        logic [DATA_W-1:0] store_data;
        logic [4:0]        except_out;
    } ex_to_mem_t;

    // Bypass back to decode
    typedef struct packed {
        logic              valid;
        logic [4:0]        addr;
        logic [DATA_W-1:0] data;
    } ex_fwd_t;

endpackage

// File: hw/ex_ctrl.sv
module ex_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic accept,
    input  logic is_div,
    input  logic div_done,
    input  logic mem_allowin,
    output logic div_start,
    output logic readygo,
    output logic occupied
);

    typedef enum logic [1:0] {
        EMPTY,
        ISSUE,
        DIV_WAIT,
        READY
    } state_e;

    state_e state;
    state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            EMPTY: begin
                if (accept) begin
                    state_next = ISSUE;
                end
            end
            ISSUE: begin
                state_next = is_div ? DIV_WAIT : READY;
            end
            DIV_WAIT: begin
                if (div_done) begin
                    state_next = READY;
                end
            end
            default: begin
                // Back-to-back when the next one arrives as this one leaves
                if (mem_allowin) begin
                    state_next = accept ? ISSUE : EMPTY;
                end
            end
        endcase
        if (flush) begin
            state_next = EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EMPTY;
        end else begin
            state <= state_next;
        end
    end

    assign div_start = (state == ISSUE) && is_div && !flush;
    assign readygo   = (state == READY);
    assign occupied  = (state != EMPTY);

endmodule

// File: hw/ex_divider.sv
module ex_divider (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          flush,
    input  ex_op_pkg::div_kind_e          kind,
    input  logic [ex_op_pkg::DATA_W-1:0]  dividend,
    input  logic [ex_op_pkg::DATA_W-1:0]  divisor,
    output logic                          done,
    output logic [ex_op_pkg::DATA_W-1:0]  quotient,
    output logic [ex_op_pkg::DATA_W-1:0]  remainder
);

    import ex_op_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } phase_e;

    phase_e                       phase;
    logic [$clog2(DIV_STEPS)-1:0] step;
    logic [DATA_W-1:0]            dsr;
    logic [DATA_W-1:0]            quo;
    logic [DATA_W-1:0]            rem;
    logic                         neg_q;
    logic                         neg_r;
    logic                         div_zero;
    logic                         is_signed;
    logic [DATA_W-1:0]            abs_a;
    logic [DATA_W-1:0]            abs_b;
    logic [DATA_W:0]              trial;
    logic [DATA_W:0]              diff;

    assign is_signed = (kind == DIV_DIV) || (kind == DIV_MOD);
    assign abs_a = (is_signed && dividend[DATA_W-1]) ? -dividend : dividend;
    assign abs_b = (is_signed && divisor[DATA_W-1]) ? -divisor : divisor;

    // Partial remainder with the next dividend bit shifted in
    assign trial = {rem, quo[DATA_W-1]};
    assign diff  = trial - {1'b0, dsr};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            phase <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                phase <= RUN;
            end else if (phase == RUN && step == $bits(step)'(DIV_STEPS - 1)) begin
                phase <= FIX;
            end else if (phase == FIX) begin
                phase <= IDLE;
                done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo      <= abs_a;
            rem      <= '0;
            dsr      <= abs_b;
            step     <= '0;
            neg_q    <= is_signed && (dividend[DATA_W-1] ^ divisor[DATA_W-1]);
            neg_r    <= is_signed && dividend[DATA_W-1];
            div_zero <= (divisor == '0);
        end else if (phase == RUN) begin
            step <= step + 1'b1;
            // Borrow set means the divisor did not fit
            if (!diff[DATA_W]) begin
                rem <= diff[DATA_W-1:0];
                quo <= {quo[DATA_W-2:0], 1'b1};
            end else begin
                rem <= trial[DATA_W-1:0];
                quo <= {quo[DATA_W-2:0], 1'b0};
            end
        end else if (phase == FIX) begin
            quotient  <= div_zero ? '1 : (neg_q ? -quo : quo);
            remainder <= neg_r ? -rem : rem;
        end
    end

endmodule

// File: hw/ex_op_pkg.sv
package ex_op_pkg;

    localparam int DATA_W = 32;

    // Shift-subtract iterations, one quotient bit each
    localparam int DIV_STEPS = 32;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // Where the stage result comes from
    typedef enum logic [2:0] {
        KIND_ALU   = 3'd0,
        KIND_MUL   = 3'd1,
        KIND_MULH  = 3'd2,
        KIND_MULHU = 3'd3,
        KIND_DIV   = 3'd4,
        KIND_CNTL  = 3'd5,
        KIND_CNTH  = 3'd6
    } ex_kind_e;

    typedef enum logic [1:0] {
        DIV_DIV  = 2'd0,
        DIV_MOD  = 2'd1,
        DIV_DIVU = 2'd2,
        DIV_MODU = 2'd3
    } div_kind_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

endpackage

// File: hw/ex_stage.sv
module ex_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          id_valid,
    input  ex_bus_pkg::id_to_ex_t         id_bus,
    output logic                          ex_allowin,
    input  logic                          mem_allowin,
    output logic                          ex_to_mem,
    output ex_bus_pkg::ex_to_mem_t        mem_bus,
    output ex_bus_pkg::ex_fwd_t           fwd,
    output logic                          ex_is_load,
    output logic                          mem_en,
    output logic                          mem_we,
    output logic [ex_op_pkg::DATA_W-1:0]  mem_addr,
    input  logic [63:0]                   counter
);

    import ex_op_pkg::*;
    import ex_bus_pkg::*;

    id_to_ex_t           inst;
    logic                accept;
    logic                occupied;
    logic                readygo;
    logic                valid;
    logic                div_start;
    logic                div_done;
    logic [DATA_W-1:0]   alu_result;
    logic [DATA_W-1:0]   quotient;
    logic [DATA_W-1:0]   remainder;
    logic [DATA_W-1:0]   div_result;
    logic [DATA_W-1:0]   cnt_snap;
    logic [DATA_W-1:0]   result;
    logic                mul_signed;
    logic [DATA_W:0]     mul_a;
    logic [DATA_W:0]     mul_b;
    logic [2*DATA_W+1:0] product;
    logic                ale;

    assign accept     = id_valid && ex_allowin && !flush;
    assign ex_allowin = !occupied || (ex_to_mem && mem_allowin);
    assign valid      = occupied && !flush;

    // Counter is sampled on accept so a held result stays put
    always_ff @(posedge clk) begin
        if (accept) begin
            inst     <= id_bus;
            cnt_snap <= (id_bus.kind == KIND_CNTH) ? counter[63:32] : counter[31:0];
        end
    end

    ex_alu u_alu (
        .op     (inst.alu_op),
        .a      (inst.src1),
        .b      (inst.src2),
        .result (alu_result)
    );

    ex_divider u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .flush     (flush),
        .kind      (inst.div_kind),
        .dividend  (inst.src1),
        .divisor   (inst.src2),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    ex_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .accept      (accept),
        .is_div      (inst.kind == KIND_DIV),
        .div_done    (div_done),
        .mem_allowin (mem_allowin),
        .div_start   (div_start),
        .readygo     (readygo),
        .occupied    (occupied)
    );

    // One 33x33 signed multiply covers all three mul forms
    assign mul_signed = (inst.kind != KIND_MULHU);
    assign mul_a      = {mul_signed & inst.src1[DATA_W-1], inst.src1};
    assign mul_b      = {mul_signed & inst.src2[DATA_W-1], inst.src2};
    assign product    = $signed(mul_a) * $signed(mul_b);

    assign div_result = (inst.div_kind == DIV_DIV || inst.div_kind == DIV_DIVU) ?
                        quotient : remainder;

    always_comb begin
        case (inst.kind)
            KIND_MUL:               result = product[DATA_W-1:0];
            KIND_MULH, KIND_MULHU:  result = product[2*DATA_W-1:DATA_W];
            KIND_DIV:               result = div_result;
            KIND_CNTL, KIND_CNTH:   result = cnt_snap;
            default:                result = alu_result;
        endcase
    end

    assign ale = (inst.mem_rd || inst.mem_wr) &&
                 ((inst.mem_size == SIZE_W && |alu_result[1:0]) ||
                  (inst.mem_size == SIZE_H && alu_result[0]));

    assign ex_to_mem  = readygo && !flush;
    assign ex_is_load = valid && inst.mem_rd;
    assign mem_en     = valid && (inst.mem_rd || inst.mem_wr);
    assign mem_we     = valid && inst.mem_wr && !ale;
    assign mem_addr   = alu_result;

    always_comb begin
        mem_bus.pc         = inst.pc;
        mem_bus.result     = result;
        mem_bus.mem_rd     = inst.mem_rd;
        mem_bus.mem_wr     = inst.mem_wr;
        mem_bus.mem_size   = inst.mem_size;
        mem_bus.mem_signed = inst.mem_signed;
        mem_bus.gr_we      = inst.gr_we;
        mem_bus.rf_waddr   = inst.rf_waddr;
        mem_bus.store_data = inst.store_data;
        mem_bus.except_out = {inst.except_in, ale};
    end

    // Loads resolve later in memory
    assign fwd.valid = ex_to_mem && inst.gr_we && !inst.mem_rd;
    assign fwd.addr  = inst.rf_waddr;
    assign fwd.data  = result;

endmodule

// File: hw/ex_top.sv
module ex_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          id_valid,
    input  ex_bus_pkg::id_to_ex_t         id_bus,
    output logic                          ex_allowin,
    input  logic                          mem_allowin,
    output logic                          ex_to_mem,
    output ex_bus_pkg::ex_to_mem_t        mem_bus,
    output ex_bus_pkg::ex_fwd_t           fwd,
    output logic                          ex_is_load,
    output logic                          mem_en,
    output logic                          mem_we,
    output logic [ex_op_pkg::DATA_W-1:0]  mem_addr
);

    logic [63:0] counter;

    stable_counter u_counter (
        .clk   (clk),
        .rst   (rst),
        .count (counter)
    );

    ex_stage u_stage (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .id_valid    (id_valid),
        .id_bus      (id_bus),
        .ex_allowin  (ex_allowin),
        .mem_allowin (mem_allowin),
        .ex_to_mem   (ex_to_mem),
        .mem_bus     (mem_bus),
        .fwd         (fwd),
        .ex_is_load  (ex_is_load),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .counter     (counter)
    );

endmodule

// File: hw/stable_counter.sv
module stable_counter (
    input  logic        clk,
    input  logic        rst,
    output logic [63:0] count
);

    // Free running, read by rdcntvl and rdcntvh
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + 64'd1;
        end
    end

endmodule

// File: test/ex_tb.sv
module ex_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import ex_op_pkg::*;
    import ex_bus_pkg::*;

    localparam int N_ALU       = 60;
    localparam int N_MUL       = 42;
    localparam int N_DIV       = 24;
    localparam int N_MEM       = 40;
    localparam int N_OTHER     = 8;
    localparam int NUM_INSTR   = N_ALU + N_MUL + N_DIV + N_MEM + N_OTHER;
    localparam int CYCLE_LIMIT = NUM_INSTR * (DIV_STEPS + 8) + 100;

    logic              clk;
    logic              rst;
    logic              flush;
    logic              id_valid;
    id_to_ex_t         id_bus;
    logic              ex_allowin;
    logic              mem_allowin;
    logic              ex_to_mem;
    ex_to_mem_t        mem_bus;
    ex_fwd_t           fwd;
    logic              ex_is_load;
    logic              mem_en;
    logic              mem_we;
    logic [DATA_W-1:0] mem_addr;

    // One entry per instruction held in the stage
    ex_to_mem_t        exp_q[$];
    ex_kind_e          kind_q[$];
    int                age;
    int                value_errors;
    int                other_errors;
    int                cycles;
    logic              held_prev;
    ex_to_mem_t        held_bus;
    ex_fwd_t           held_fwd;
    logic              have_cnt;
    logic [DATA_W-1:0] last_cnt;

    ex_top uut (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .id_valid    (id_valid),
        .id_bus      (id_bus),
        .ex_allowin  (ex_allowin),
        .mem_allowin (mem_allowin),
        .ex_to_mem   (ex_to_mem),
        .mem_bus     (mem_bus),
        .fwd         (fwd),
        .ex_is_load  (ex_is_load),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic value_error(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        value_errors++;
        $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic check_failed(input string what);
        other_errors++;
        $display("Error at t=%0t: %s", $time, what);
    endtask

    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_NOR:  return ~(a | b);
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return ext[31:0];
            default:  return b;
        endcase
    endfunction

    function automatic ex_to_mem_t predict(id_to_ex_t b);
        ex_to_mem_t  e;
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] prod;
        longint      num;
        longint      den;
        logic [31:0] q;
        logic [31:0] r;
        logic        ale;
        sa = {{32{b.src1[31]}}, b.src1};
        sb = {{32{b.src2[31]}}, b.src2};
        e = '0;
        case (b.kind)
            KIND_MUL, KIND_MULH: begin
                prod = sa * sb;
                e.result = (b.kind == KIND_MUL) ? prod[31:0] : prod[63:32];
            end
            KIND_MULHU: begin
                prod = {32'd0, b.src1} * {32'd0, b.src2};
                e.result = prod[63:32];
            end
            KIND_DIV: begin
                if (b.div_kind == DIV_DIV || b.div_kind == DIV_MOD) begin
                    num = sa;
                    den = sb;
                end else begin
                    num = {32'd0, b.src1};
                    den = {32'd0, b.src2};
                end
                if (b.src2 == '0) begin
                    q = '1;
                    r = b.src1;
                end else begin
                    q = 32'(num / den);
                    r = 32'(num % den);
                end
                e.result = (b.div_kind == DIV_DIV || b.div_kind == DIV_DIVU) ? q : r;
            end
            // Counter reads are checked by their own rules
            KIND_CNTL, KIND_CNTH: begin
                e.result = '0;
            end
            default: begin
                e.result = alu_ref(b.alu_op, b.src1, b.src2);
            end
        endcase
        ale = (b.mem_rd || b.mem_wr) &&
              ((b.mem_size == SIZE_W && e.result[1:0] != 2'b00) ||
               (b.mem_size == SIZE_H && e.result[0]));
        e.pc         = b.pc;
        e.mem_rd     = b.mem_rd;
        e.mem_wr     = b.mem_wr;
        e.mem_size   = b.mem_size;
        e.mem_signed = b.mem_signed;
        e.gr_we      = b.gr_we;
        e.rf_waddr   = b.rf_waddr;
        e.store_data = b.store_data;
        e.except_out = {b.except_in, ale};
        return e;
    endfunction

    function automatic logic [31:0] rand_word();
        case ($urandom % 8)
            0:       return 32'd0;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [31:0] edge_word(int n);
        case (n)
            0:       return 32'd0;
            1:       return 32'hffff_ffff;
            default: return 32'h8000_0000;
        endcase
    endfunction

    function automatic id_to_ex_t base_inst();
        id_to_ex_t b;
        b = '0;
        b.pc         = $urandom & 32'hffff_fffc;
        b.alu_op     = ALU_ADD;
        b.kind       = KIND_ALU;
        b.div_kind   = DIV_DIV;
        b.mem_size   = SIZE_W;
        b.gr_we      = $urandom % 2;
        b.rf_waddr   = $urandom % 32;
        b.store_data = $urandom;
        b.except_in  = $urandom % 16;
        return b;
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send(input id_to_ex_t b);
        id_bus   = b;
        id_valid = 1'b1;
        @(posedge clk);
        while (!ex_allowin) begin
            @(posedge clk);
        end
        @(negedge clk);
        id_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Outputs are read at the rising edge, before the DUT registers update
    always @(posedge clk) begin : monitor
        ex_to_mem_t        head;
        ex_to_mem_t        act;
        logic              is_cnt;
        logic              exp_allow;
        logic [DATA_W-1:0] exp_data;
        head   = (exp_q.size() > 0) ? exp_q[0] : '0;
        is_cnt = (exp_q.size() > 0) && (kind_q[0] == KIND_CNTL || kind_q[0] == KIND_CNTH);
        if (rst) begin
            held_prev = 1'b0;
        end else begin
            exp_allow = (exp_q.size() == 0) || (ex_to_mem && mem_allowin);
            assert (ex_allowin == exp_allow)
                else value_error("ex_allowin", exp_allow, ex_allowin);
            if (flush) begin
                assert (!ex_to_mem && !fwd.valid && !mem_en && !ex_is_load)
                    else check_failed("stage outputs active while flush is high");
            end
            if (exp_q.size() == 0) begin
                assert (!ex_to_mem && !mem_en && !ex_is_load && !fwd.valid)
                    else check_failed("stage outputs active while no instruction is held");
            end else if (!flush) begin
                assert (mem_en == (head.mem_rd || head.mem_wr))
                    else value_error("mem_en", head.mem_rd || head.mem_wr, mem_en);
                assert (ex_is_load == head.mem_rd)
                    else value_error("ex_is_load", head.mem_rd, ex_is_load);
                assert (mem_we == (head.mem_wr && !head.except_out[0]))
                    else value_error("mem_we", head.mem_wr && !head.except_out[0], mem_we);
                if (head.mem_rd || head.mem_wr) begin
                    assert (mem_addr == head.result)
                        else value_error("mem_addr", head.result, mem_addr);
                end
                if (kind_q[0] != KIND_DIV && age >= 1) begin
                    assert (ex_to_mem)
                        else check_failed("result not ready one cycle after issue");
                end
            end
            if (held_prev && !flush) begin
                assert (ex_to_mem)
                    else check_failed("ex_to_mem dropped while memory held the result back");
                assert (mem_bus == held_bus)
                    else value_error("mem_bus", held_bus, mem_bus);
                assert (fwd == held_fwd)
                    else value_error("fwd", held_fwd, fwd);
            end
            if (ex_to_mem && exp_q.size() > 0) begin
                act      = mem_bus;
                exp_data = head.result;
                if (is_cnt) begin
                    act.result = head.result;
                    exp_data   = mem_bus.result;
                end
                assert (act == head)
                    else value_error("mem_bus", head, mem_bus);
                assert (fwd.valid == (head.gr_we && !head.mem_rd))
                    else value_error("fwd.valid", head.gr_we && !head.mem_rd, fwd.valid);
                if (fwd.valid) begin
                    assert (fwd.addr == head.rf_waddr && fwd.data == exp_data)
                        else value_error("fwd", {head.rf_waddr, exp_data},
                                         {fwd.addr, fwd.data});
                end
            end
            if (!ex_to_mem) begin
                assert (!fwd.valid)
                    else check_failed("fwd.valid high without a ready result");
            end
            if (ex_to_mem && mem_allowin && exp_q.size() > 0) begin
                if (kind_q[0] == KIND_CNTL) begin
                    if (have_cnt) begin
                        assert (mem_bus.result > last_cnt)
                            else check_failed("stable counter low word did not increase");
                    end
                    last_cnt = mem_bus.result;
                    have_cnt = 1'b1;
                end else if (kind_q[0] == KIND_CNTH) begin
                    assert (mem_bus.result == '0)
                        else value_error("mem_bus.result", 0, mem_bus.result);
                end
                void'(exp_q.pop_front());
                void'(kind_q.pop_front());
            end
            if (flush && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(kind_q.pop_front());
            end
            if (id_valid && ex_allowin) begin
                exp_q.push_back(predict(id_bus));
                kind_q.push_back(id_bus.kind);
                age = 0;
            end else begin
                age = age + 1;
            end
            held_prev = ex_to_mem && !mem_allowin;
            held_bus  = mem_bus;
            held_fwd  = fwd;
        end
    end

    // Memory stage back-pressure
    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                mem_allowin = ($urandom % 4) != 0;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the stage stopped making progress", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        id_to_ex_t b;
        void'($urandom(32'h354a_05e5));
        rst          = 1'b1;
        flush        = 1'b0;
        id_valid     = 1'b0;
        id_bus       = '0;
        mem_allowin  = 1'b1;
        value_errors = 0;
        other_errors = 0;
        held_prev    = 1'b0;
        have_cnt     = 1'b0;
        last_cnt     = '0;
        age          = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_ALU; i++) begin
            b = base_inst();
            b.alu_op = alu_op_e'(i % 12);
            b.src1 = rand_word();
            b.src2 = rand_word();
            send(b);
        end

        // All nine edge pairs for each mul form, then random operands
        for (int i = 0; i < N_MUL; i++) begin
            b = base_inst();
            b.kind = ex_kind_e'(1 + i % 3);
            b.src1 = (i < 27) ? edge_word((i / 3) % 3) : rand_word();
            b.src2 = (i < 27) ? edge_word(i / 9) : rand_word();
            send(b);
        end

        for (int i = 0; i < N_DIV; i++) begin
            b = base_inst();
            b.kind = KIND_DIV;
            b.div_kind = div_kind_e'(i % 4);
            b.src1 = (i >= 4 && i < 8) ? 32'h8000_0000 : rand_word();
            b.src2 = (i < 4) ? 32'd0 : ((i < 8) ? 32'hffff_ffff : rand_word());
            send(b);
        end

        for (int i = 0; i < N_MEM; i++) begin
            b = base_inst();
            b.mem_rd = (i % 2 == 1);
            b.mem_wr = (i % 2 == 0);
            b.gr_we = b.mem_rd;
            b.mem_size = mem_size_e'($urandom % 3);
            b.mem_signed = $urandom % 2;
            b.src1 = $urandom;
            b.src2 = $urandom % 16;
            send(b);
        end

        // Flush a load in issue, a ready ALU result, then a divide in flight
        b = base_inst();
        b.mem_rd = 1'b1;
        b.gr_we  = 1'b1;
        b.src1   = $urandom;
        send(b);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        b = base_inst();
        b.gr_we = 1'b1;
        b.src1  = $urandom;
        send(b);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        b.src2 = $urandom;
        send(b);
        b = base_inst();
        b.kind = KIND_DIV;
        b.src1 = $urandom;
        b.src2 = $urandom % 1000 + 1;
        send(b);
        repeat (5) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        b.pc = b.pc + 32'd4;
        send(b);

        drain();
        b = base_inst();
        b.kind = KIND_CNTL;
        send(b);
        drain();
        repeat (10) @(negedge clk);
        send(b);
        b.kind = KIND_CNTH;
        send(b);
        drain();

        repeat (3) @(negedge clk);
        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/ex_op_pkg.sv
hw/ex_bus_pkg.sv
hw/ex_alu.sv
hw/ex_divider.sv
hw/ex_ctrl.sv
hw/ex_stage.sv
hw/stable_counter.sv
hw/ex_top.sv
test/ex_tb.sv
